/* src/graph_ctx_pkg.sv */
`default_nettype none

package graph_ctx_pkg;

    // graph size in x, z and rounds
    localparam int GRID_WIDTH_X = 4;
    localparam int GRID_WIDTH_Z = 2;
    localparam int GRID_WIDTH_U = 8;

    localparam int NUM_CONTEXTS = 4;  // time slices per pass
    localparam int NUM_FPGAS = 5;     // boards in the chain

    // rounds held per context, rounded up
    localparam int PHYSICAL_LAYERS = (GRID_WIDTH_U % NUM_CONTEXTS == 0) ?
        (GRID_WIDTH_U / NUM_CONTEXTS) : (GRID_WIDTH_U / NUM_CONTEXTS + 1);
    localparam int PU_PER_LAYER = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_PER_LAYER * PHYSICAL_LAYERS;

    localparam int X_BITS = $clog2(GRID_WIDTH_X);
    localparam int Z_BITS = $clog2(GRID_WIDTH_Z);
    localparam int U_BITS = $clog2(GRID_WIDTH_U);
    localparam int FPGA_BITS = $clog2(NUM_FPGAS);
    localparam int CTX_BITS = $clog2(NUM_CONTEXTS) + 1;  // one bit of headroom

    localparam logic [CTX_BITS-1:0] LAST_CONTEXT = CTX_BITS'(NUM_CONTEXTS - 1);

    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_PEEL                = 3'd4,
        STAGE_WRITE_TO_MEM        = 3'd5
    } stage_e;

    // encoding seen by the links
    typedef enum logic [1:0] {
        LINK_INTERNAL   = 2'b00,
        LINK_BOUNDARY   = 2'b01,
        LINK_ABSENT     = 2'b10,
        LINK_CROSS_FPGA = 2'b11
    } link_type_e;

    typedef struct packed {
        logic                 valid;
        logic [FPGA_BITS-1:0] fpga_id;
        logic [U_BITS-1:0]    u;      // round coordinate
        logic [X_BITS-1:0]    x;
        logic [Z_BITS-1:0]    z;
    } pu_address_t;

    typedef struct packed {
        logic [CTX_BITS-1:0] current;
        logic [CTX_BITS-1:0] delayed;  // current, one cycle late
    } ctx_state_t;

    typedef struct packed {
        link_type_e bottom_type;
        link_type_e top_type;
        link_type_e north_cut_type;
        link_type_e south_cut_type;
        logic       bottom_do_not_store;
        logic       top_do_not_store;
    } link_state_t;

endpackage

`default_nettype wire

/* src/context_sequencer.sv */
`default_nettype none

module context_sequencer (
    input  wire                       clk,
    input  wire                       reset,
    input  graph_ctx_pkg::stage_e     global_stage_i,
    output graph_ctx_pkg::ctx_state_t ctx_o
);

    graph_ctx_pkg::ctx_state_t ctx_q;
    logic                      advance;

    // one step per write-to-memory stage
    assign advance = (global_stage_i == graph_ctx_pkg::STAGE_WRITE_TO_MEM);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctx_q.current <= '0;
        end else if (advance) begin
            if (ctx_q.current == graph_ctx_pkg::LAST_CONTEXT) begin
                ctx_q.current <= '0;  // wrap, next pass
            end else begin
                ctx_q.current <= ctx_q.current + 1'b1;
            end
        end
    end

    // the delayed copy lets the vertical link types settle in the graph
    // one cycle before the unit addresses move to the new slice
    always_ff @(posedge clk) begin
        if (reset) begin
            ctx_q.delayed <= '0;
        end else begin
            ctx_q.delayed <= ctx_q.current;
        end
    end

    assign ctx_o = ctx_q;

endmodule

`default_nettype wire

/* src/layer_address_map.sv */
`default_nettype none

module layer_address_map (
    input  graph_ctx_pkg::ctx_state_t               ctx_i,
    input  wire [graph_ctx_pkg::FPGA_BITS-1:0]      fpga_id_i,
    output graph_ctx_pkg::pu_address_t              pu_address_o [graph_ctx_pkg::PU_COUNT]
);

    logic                             odd_ctx;
    logic [graph_ctx_pkg::U_BITS-1:0] base_u;

    // snake order, odd slices run backward in u
    assign odd_ctx = ctx_i.delayed[0];

    // first round covered by this slice
    assign base_u = graph_ctx_pkg::U_BITS'(ctx_i.delayed) *
                    graph_ctx_pkg::U_BITS'(graph_ctx_pkg::PHYSICAL_LAYERS);

    for (genvar layer = 0; layer < graph_ctx_pkg::PHYSICAL_LAYERS; layer++) begin : g_layer
        logic [graph_ctx_pkg::U_BITS-1:0] layer_u;  // offset inside the slice

        assign layer_u = odd_ctx ?
            graph_ctx_pkg::U_BITS'(graph_ctx_pkg::PHYSICAL_LAYERS - 1 - layer) :
            graph_ctx_pkg::U_BITS'(layer);

        for (genvar x = 0; x < graph_ctx_pkg::GRID_WIDTH_X; x++) begin : g_x
            for (genvar z = 0; z < graph_ctx_pkg::GRID_WIDTH_Z; z++) begin : g_z
                // unit index is layer-major, then x, then z
                assign pu_address_o[layer * graph_ctx_pkg::PU_PER_LAYER
                                    + x * graph_ctx_pkg::GRID_WIDTH_Z + z] = '{
                    valid:   1'b1,
                    fpga_id: fpga_id_i,
                    u:       base_u + layer_u,
                    x:       graph_ctx_pkg::X_BITS'(x),
                    z:       graph_ctx_pkg::Z_BITS'(z)
                };
            end
        end
    end

endmodule

`default_nettype wire

/* src/vertical_link_scheduler.sv */
`default_nettype none

module vertical_link_scheduler (
    input  graph_ctx_pkg::ctx_state_t  ctx_i,
    input  wire [1:0]                  border_continuous_i,
    output graph_ctx_pkg::link_state_t link_state_o
);

    logic first_ctx;
    logic last_ctx;
    logic delayed_last;
    logic delayed_odd;

    // link types track the current context, so the graph sees them
    // before the addresses (delayed context) change
    assign first_ctx = (ctx_i.current == '0);
    assign last_ctx  = (ctx_i.current == graph_ctx_pkg::LAST_CONTEXT);

    assign delayed_last = (ctx_i.delayed == graph_ctx_pkg::LAST_CONTEXT);
    assign delayed_odd  = ctx_i.delayed[0];

    always_comb begin
        // bottom of the first slice touches the time boundary
        if (first_ctx) begin
            link_state_o.bottom_type = graph_ctx_pkg::LINK_BOUNDARY;
        end else begin
            link_state_o.bottom_type = graph_ctx_pkg::LINK_INTERNAL;
        end

        // nothing above the last slice
        if (last_ctx) begin
            link_state_o.top_type = graph_ctx_pkg::LINK_ABSENT;
        end else begin
            link_state_o.top_type = graph_ctx_pkg::LINK_INTERNAL;
        end

        // border cuts, continuous border means a neighbor board
        link_state_o.north_cut_type = border_continuous_i[0] ?
            graph_ctx_pkg::LINK_CROSS_FPGA : graph_ctx_pkg::LINK_ABSENT;
        link_state_o.south_cut_type = border_continuous_i[1] ?
            graph_ctx_pkg::LINK_CROSS_FPGA : graph_ctx_pkg::LINK_ABSENT;

        // support units hold the side of the slice that the next
        // context reuses, the other side must not be overwritten
        link_state_o.top_do_not_store    = !delayed_odd && !delayed_last;
        link_state_o.bottom_do_not_store = delayed_odd && !delayed_last;
    end

endmodule

`default_nettype wire

/* src/layer_descriptor_builder.sv */
`default_nettype none

module layer_descriptor_builder (
    input  wire                        clk,
    input  wire                        reset,
    input  graph_ctx_pkg::ctx_state_t  ctx_i,
    input  graph_ctx_pkg::pu_address_t pu_address_i [graph_ctx_pkg::PU_COUNT],
    input  graph_ctx_pkg::link_state_t link_state_i,
    output graph_ctx_pkg::pu_address_t pu_address_o [graph_ctx_pkg::PU_COUNT],
    output graph_ctx_pkg::link_state_t link_state_o,
    output logic                       context_ready_o,
    output logic                       round_done_o
);

    graph_ctx_pkg::pu_address_t       pu_address_q [graph_ctx_pkg::PU_COUNT];
    graph_ctx_pkg::link_state_t       link_state_q;
    logic [graph_ctx_pkg::CTX_BITS-1:0] addr_ctx_q;  // slice held in pu_address_q
    logic                             loaded_q;
    logic                             match_q;
    logic                             round_done_q;

    // snapshots, refreshed every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pu_address_q <= '{default: '0};  // valid bits low
            link_state_q <= '0;
        end else begin
            pu_address_q <= pu_address_i;
            link_state_q <= link_state_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_ctx_q   <= '0;
            loaded_q     <= 1'b0;
            match_q      <= 1'b0;
            round_done_q <= 1'b0;
        end else begin
            addr_ctx_q <= ctx_i.delayed;
            loaded_q   <= 1'b1;  // first snapshot taken
            // addresses taken at this edge belong to the counter value
            match_q    <= (ctx_i.delayed == ctx_i.current);
            // last slice handed over to slice 0, one pass complete
            round_done_q <= loaded_q
                            && (addr_ctx_q == graph_ctx_pkg::LAST_CONTEXT)
                            && (ctx_i.delayed == '0);
        end
    end

    assign pu_address_o    = pu_address_q;
    assign link_state_o    = link_state_q;
    assign context_ready_o = loaded_q & match_q;
    assign round_done_o    = round_done_q;  // one cycle wide

endmodule

`default_nettype wire

/* src/decoding_graph_context.sv */
`default_nettype none

module decoding_graph_context (
    input  wire                                clk,
    input  wire                                reset,
    input  graph_ctx_pkg::stage_e              global_stage_i,
    input  wire [graph_ctx_pkg::FPGA_BITS-1:0] fpga_id_i,
    input  wire [1:0]                          border_continuous_i,
    output graph_ctx_pkg::pu_address_t         pu_address_o [graph_ctx_pkg::PU_COUNT],
    output graph_ctx_pkg::link_state_t         link_state_o,
    output logic                               context_ready_o,
    output logic                               round_done_o
);

    graph_ctx_pkg::ctx_state_t  ctx;
    graph_ctx_pkg::pu_address_t pu_address [graph_ctx_pkg::PU_COUNT];
    graph_ctx_pkg::link_state_t link_state;

    context_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .global_stage_i (global_stage_i),
        .ctx_o          (ctx)
    );

    // address map and link scheduler both work from the same context
    layer_address_map u_address_map (
        .ctx_i        (ctx),
        .fpga_id_i    (fpga_id_i),
        .pu_address_o (pu_address)
    );

    vertical_link_scheduler u_link_scheduler (
        .ctx_i               (ctx),
        .border_continuous_i (border_continuous_i),
        .link_state_o        (link_state)
    );

    layer_descriptor_builder u_builder (
        .clk             (clk),
        .reset           (reset),
        .ctx_i           (ctx),
        .pu_address_i    (pu_address),
        .link_state_i    (link_state),
        .pu_address_o    (pu_address_o),
        .link_state_o    (link_state_o),
        .context_ready_o (context_ready_o),
        .round_done_o    (round_done_o)
    );

endmodule

`default_nettype wire

/* testbench/decoding_graph_context_checker.sv */
`default_nettype none

module decoding_graph_context_checker (
    input  wire                                clk,
    input  wire                                reset,
    input  graph_ctx_pkg::stage_e              global_stage_i,
    input  wire [graph_ctx_pkg::FPGA_BITS-1:0] fpga_id_i,
    input  wire [1:0]                          border_continuous_i,
    input  graph_ctx_pkg::pu_address_t         pu_address_o [graph_ctx_pkg::PU_COUNT],
    input  graph_ctx_pkg::link_state_t         link_state_o,
    input  wire                                context_ready_o,
    input  wire                                round_done_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAST = graph_ctx_pkg::NUM_CONTEXTS - 1;
    localparam int PL = graph_ctx_pkg::PHYSICAL_LAYERS;

    int ctx_m;   // model context, follows each write-to-memory stage
    int ctx_p1;
    int ctx_p2;
    int settle_cnt;
    logic strobe;
    logic st1, st2, st3;      // strobe history
    logic wrap1, wrap2, wrap3;  // strobes that wrapped to context 0
    logic armed;
    logic [graph_ctx_pkg::FPGA_BITS-1:0] fpga_p1;
    logic [1:0] border_p1;

    graph_ctx_pkg::pu_address_t exp_addr [graph_ctx_pkg::PU_COUNT];
    graph_ctx_pkg::link_type_e  exp_bottom;
    graph_ctx_pkg::link_type_e  exp_top;
    graph_ctx_pkg::link_type_e  exp_north;
    graph_ctx_pkg::link_type_e  exp_south;
    logic [1:0]                 exp_dns;  // bottom, top

    // first failure, read by the testbench
    logic        fail_seen = 1'b0;
    string       fail_test = "";
    logic [31:0] fail_expected = '0;
    logic [31:0] fail_actual = '0;

    function automatic graph_ctx_pkg::pu_address_t snake_address(input int unit, input int ctx,
            input logic [graph_ctx_pkg::FPGA_BITS-1:0] fpga);
        graph_ctx_pkg::pu_address_t addr;
        int layer;
        int offset;
        int u;
        layer  = unit / graph_ctx_pkg::PU_PER_LAYER;
        offset = unit % graph_ctx_pkg::PU_PER_LAYER;
        if (ctx % 2 == 0) begin
            u = ctx * PL + layer;
        end else begin
            u = ctx * PL + PL - 1 - layer;  // odd slices walk backward
        end
        addr.valid   = 1'b1;
        addr.fpga_id = fpga;
        addr.u       = graph_ctx_pkg::U_BITS'(u);
        addr.x       = graph_ctx_pkg::X_BITS'(offset / graph_ctx_pkg::GRID_WIDTH_Z);
        addr.z       = graph_ctx_pkg::Z_BITS'(offset % graph_ctx_pkg::GRID_WIDTH_Z);
        return addr;
    endfunction

    task automatic note_failure(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (!fail_seen) begin
            fail_test     = name;
            fail_expected = expected;
            fail_actual   = actual;
            fail_seen     = 1'b1;
        end
    endtask

    assign strobe = (global_stage_i == graph_ctx_pkg::STAGE_WRITE_TO_MEM);
    assign armed  = (settle_cnt >= 4);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctx_m      <= 0;
            ctx_p1     <= 0;
            ctx_p2     <= 0;
            settle_cnt <= 0;
            {st1, st2, st3}       <= '0;
            {wrap1, wrap2, wrap3} <= '0;
            fpga_p1    <= '0;
            border_p1  <= '0;
        end else begin
            if (strobe) begin
                ctx_m <= (ctx_m == LAST) ? 0 : ctx_m + 1;
            end
            ctx_p1 <= ctx_m;
            ctx_p2 <= ctx_p1;
            if (settle_cnt < 4) begin
                settle_cnt <= settle_cnt + 1;
            end
            st1   <= strobe;
            st2   <= st1;
            st3   <= st2;
            wrap1 <= strobe && (ctx_m == LAST);
            wrap2 <= wrap1;
            wrap3 <= wrap2;
            fpga_p1   <= fpga_id_i;  // value the address registers took
            border_p1 <= border_continuous_i;
        end
    end

    always_comb begin
        for (int i = 0; i < graph_ctx_pkg::PU_COUNT; i++) begin
            exp_addr[i] = snake_address(i, ctx_p2, fpga_p1);
        end
        exp_bottom = (ctx_p1 == 0) ? graph_ctx_pkg::LINK_BOUNDARY : graph_ctx_pkg::LINK_INTERNAL;
        exp_top    = (ctx_p1 == LAST) ? graph_ctx_pkg::LINK_ABSENT : graph_ctx_pkg::LINK_INTERNAL;
        exp_north  = border_p1[0] ? graph_ctx_pkg::LINK_CROSS_FPGA : graph_ctx_pkg::LINK_ABSENT;
        exp_south  = border_p1[1] ? graph_ctx_pkg::LINK_CROSS_FPGA : graph_ctx_pkg::LINK_ABSENT;
        exp_dns[1] = (ctx_p2 % 2 == 1) && (ctx_p2 != LAST);
        exp_dns[0] = (ctx_p2 % 2 == 0) && (ctx_p2 != LAST);
    end

    for (genvar i = 0; i < graph_ctx_pkg::PU_COUNT; i++) begin : g_unit
        a_unit_address: assert property (@(posedge clk) disable iff (!armed)
            (st3 && !st2) |-> (pu_address_o[i] == exp_addr[i]))
        else begin
            note_failure($sformatf("unit_address_%0d", i), 32'($sampled(exp_addr[i])),
                         32'($sampled(pu_address_o[i])));
            $error("unit %0d address is off the snake order", i);
        end
    end

    a_bottom_type: assert property (@(posedge clk) disable iff (!armed)
        st2 |-> (link_state_o.bottom_type == exp_bottom))
    else begin
        note_failure("bottom_link_type", 32'($sampled(exp_bottom)),
                     32'($sampled(link_state_o.bottom_type)));
        $error("bottom link type wrong one cycle after a strobe");
    end

    a_top_type: assert property (@(posedge clk) disable iff (!armed)
        st2 |-> (link_state_o.top_type == exp_top))
    else begin
        note_failure("top_link_type", 32'($sampled(exp_top)),
                     32'($sampled(link_state_o.top_type)));
        $error("top link type wrong one cycle after a strobe");
    end

    a_do_not_store: assert property (@(posedge clk) disable iff (!armed)
        (st3 && !st2) |-> ({link_state_o.bottom_do_not_store,
                            link_state_o.top_do_not_store} == exp_dns))
    else begin
        note_failure("do_not_store", 32'($sampled(exp_dns)),
                     32'($sampled({link_state_o.bottom_do_not_store,
                                   link_state_o.top_do_not_store})));
        $error("support unit do-not-store flags wrong");
    end

    a_cut_types: assert property (@(posedge clk) disable iff (!armed)
        (link_state_o.north_cut_type == exp_north) && (link_state_o.south_cut_type == exp_south))
    else begin
        note_failure("border_cut_types", 32'($sampled({exp_north, exp_south})),
                     32'($sampled({link_state_o.north_cut_type, link_state_o.south_cut_type})));
        $error("border cut types do not follow border_continuous_i");
    end

    a_ready_low: assert property (@(posedge clk) disable iff (!armed)
        st2 |-> !context_ready_o)
    else begin
        note_failure("context_ready_low", 32'd0, 32'($sampled(context_ready_o)));
        $error("context_ready_o high right after a strobe");
    end

    a_ready_high: assert property (@(posedge clk) disable iff (!armed)
        (st3 && !st2) |-> context_ready_o)
    else begin
        note_failure("context_ready_high", 32'd1, 32'($sampled(context_ready_o)));
        $error("context_ready_o still low two cycles after a strobe");
    end

    a_round_done: assert property (@(posedge clk) disable iff (!armed)
        round_done_o == wrap3)
    else begin
        note_failure("round_done", 32'($sampled(wrap3)), 32'($sampled(round_done_o)));
        $error("round_done_o out of step with the context wrap");
    end

endmodule

`default_nettype wire

/* testbench/tb_decoding_graph_context.sv */
`default_nettype none

module tb_decoding_graph_context;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_STROBES = 48;
    localparam int MIN_GAP = 3;
    localparam int MAX_GAP = 8;
    localparam int SEED = 9186;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_STROBES * MAX_GAP * 2;

    logic clk = 1'b0;
    logic reset;
    graph_ctx_pkg::stage_e                global_stage;
    logic [graph_ctx_pkg::FPGA_BITS-1:0] fpga_id;
    logic [1:0]                           border_continuous;
    graph_ctx_pkg::pu_address_t           pu_address [graph_ctx_pkg::PU_COUNT];
    graph_ctx_pkg::link_state_t           link_state;
    logic                                 context_ready;
    logic                                 round_done;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    decoding_graph_context i_dut (
        .clk                 (clk),
        .reset               (reset),
        .global_stage_i      (global_stage),
        .fpga_id_i           (fpga_id),
        .border_continuous_i (border_continuous),
        .pu_address_o        (pu_address),
        .link_state_o        (link_state),
        .context_ready_o     (context_ready),
        .round_done_o        (round_done)
    );

    bind decoding_graph_context decoding_graph_context_checker u_checker (
        .clk                 (clk),
        .reset               (reset),
        .global_stage_i      (global_stage_i),
        .fpga_id_i           (fpga_id_i),
        .border_continuous_i (border_continuous_i),
        .pu_address_o        (pu_address_o),
        .link_state_o        (link_state_o),
        .context_ready_o     (context_ready_o),
        .round_done_o        (round_done_o)
    );

    // inputs change just after the edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_random_stage();
        global_stage = graph_ctx_pkg::stage_e'(3'($urandom_range(4, 0)));  // idle .. peel
    endtask

    task automatic randomize_board_inputs();
        fpga_id = graph_ctx_pkg::FPGA_BITS'($urandom_range(graph_ctx_pkg::NUM_FPGAS - 1, 0));
        border_continuous = 2'($urandom_range(3, 0));
    endtask

    task automatic show_first_failure();
        $display("** Error: test %s, expected 0x%0h, actual 0x%0h",
                 i_dut.u_checker.fail_test, i_dut.u_checker.fail_expected,
                 i_dut.u_checker.fail_actual);
    endtask

    initial begin : stimulus
        int gap;
        int short_a;
        int short_b;
        void'($urandom(SEED));
        reset = 1'b1;
        global_stage = graph_ctx_pkg::STAGE_IDLE;
        fpga_id = '0;
        border_continuous = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // two strobes follow the previous one after a single cycle
        short_a = $urandom_range(NUM_STROBES / 2 - 1, 1);
        short_b = $urandom_range(NUM_STROBES - 1, NUM_STROBES / 2);

        for (int s = 0; s < NUM_STROBES; s++) begin
            if (s == short_a || s == short_b) begin
                gap = 1;
            end else begin
                gap = $urandom_range(MAX_GAP, MIN_GAP);
            end
            for (int g = 0; g < gap; g++) begin
                drive_random_stage();
                if (g == 0) begin
                    randomize_board_inputs();
                end
                step_cycle();
            end
            global_stage = graph_ctx_pkg::STAGE_WRITE_TO_MEM;
            step_cycle();
        end

        global_stage = graph_ctx_pkg::STAGE_IDLE;
        repeat (MAX_GAP) step_cycle();  // let the last checks fire

        if (i_dut.u_checker.fail_seen) begin
            show_first_failure();
            $display("Errors found");
            $fatal(1, "run ended with a failed check");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    initial begin : failure_monitor
        wait (i_dut.u_checker.fail_seen == 1'b1);
        show_first_failure();
        $display("Errors found");
        $fatal(1, "stopped at the first failed check");
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "run stopped by the watchdog");
    end

endmodule

`default_nettype wire

/* project.f */
src/graph_ctx_pkg.sv
src/context_sequencer.sv
src/layer_address_map.sv
src/vertical_link_scheduler.sv
src/layer_descriptor_builder.sv
src/decoding_graph_context.sv
testbench/decoding_graph_context_checker.sv
testbench/tb_decoding_graph_context.sv

/* Makefile */
TOP := tb_decoding_graph_context
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation gave no result, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
